/* all.f */
hw/mem_bus_pkg.sv
hw/lsu_pkg.sv
hw/data_sram.sv
hw/bus_arbiter.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/mem_subsys.sv
bench/mem_subsys_tb.sv

/* bench/mem_subsys_stim.txt */
// kind addr size unsigned data expected, all hex; size 0 byte, 1 half, 2 word
// kind 1 store, 2 load, 3 fetch, 4 load with fetch (data holds the instruction), 0 end
1 00000100 2 0 89abcdef 00000000
2 00000100 2 0 00000000 89abcdef
1 00000104 2 0 fe807f01 00000000
2 00000100 0 0 00000000 ffffffef
2 00000101 0 1 00000000 000000cd
2 00000102 0 0 00000000 ffffffab
2 00000103 0 0 00000000 ffffff89
2 00000104 0 0 00000000 00000001
2 00000105 0 0 00000000 0000007f
2 00000106 0 0 00000000 ffffff80
2 00000107 0 1 00000000 000000fe
2 00000100 1 0 00000000 ffffcdef
2 00000101 1 1 00000000 0000abcd
2 00000102 1 0 00000000 ffff89ab
2 00000103 1 0 00000000 00000189
2 00000104 1 1 00000000 00007f01
2 00000105 1 0 00000000 ffff807f
2 00000106 1 0 00000000 fffffe80
1 00000101 0 0 ffffff5a 00000000
1 00000102 1 0 dead1234 00000000
2 00000100 2 0 00000000 12345aef
1 00000200 2 0 33221100 00000000
1 00000204 2 0 77665544 00000000
1 00000208 2 0 bbaa9988 00000000
1 0000020c 2 0 ffeeddcc 00000000
1 00000205 2 0 a1b2c3d4 00000000
2 00000205 2 0 00000000 a1b2c3d4
2 00000204 2 0 00000000 b2c3d444
2 00000208 2 0 00000000 bbaa99a1
1 00000206 2 0 0badf00d 00000000
2 00000206 2 0 00000000 0badf00d
2 0000020a 1 1 00000000 0000bbaa
1 00000207 2 0 13579bdf 00000000
2 00000207 2 0 00000000 13579bdf
2 00000206 0 0 00000000 0000000d
1 0000020f 1 0 00008421 00000000
2 0000020f 1 0 00000000 ffff8421
2 0000020c 2 0 00000000 21eeddcc
3 00000100 2 0 00000000 12345aef
3 00000104 2 0 00000000 fe807f01
3 00000204 2 0 00000000 df0dd444
3 00000208 2 0 00000000 bb13579b
4 00000207 2 0 df0dd444 13579bdf
4 0000020d 0 1 21eeddcc 000000dd
4 00000106 1 0 fe807f01 fffffe80
0 00000000 0 0 00000000 00000000

/* bench/mem_subsys_tb.sv */
`timescale 1ns/1ns

module mem_subsys_tb;

  localparam int MAX_VEC = 64;
  localparam int TIMEOUT = 50;

  // vector kinds in the data file
  localparam logic [31:0] KIND_END   = 32'd0;
  localparam logic [31:0] KIND_STORE = 32'd1;
  localparam logic [31:0] KIND_LOAD  = 32'd2;
  localparam logic [31:0] KIND_FETCH = 32'd3;
  localparam logic [31:0] KIND_PAIR  = 32'd4;

  logic                 clk;
  logic                 rst;
  logic                 lsu_req_valid;
  logic                 lsu_req_ready;
  lsu_pkg::lsu_req_t    lsu_req;
  logic                 lsu_rsp_valid;
  lsu_pkg::lsu_rsp_t    lsu_rsp;
  logic                 fetch_req_valid;
  logic                 fetch_req_ready;
  mem_bus_pkg::addr_t   fetch_pc;
  logic                 fetch_rsp_valid;
  mem_bus_pkg::word32_t fetch_instr;

  // six words per vector: kind, addr, size, unsigned, data, expected
  logic [31:0] vec_mem [6*MAX_VEC];
  int          errors;
  int          timeouts;

  mem_subsys #(.DEPTH_WORDS(256)) mem_subsys_inst (
    .clk(clk), .rst(rst),
    .lsu_req_valid(lsu_req_valid), .lsu_req_ready(lsu_req_ready), .lsu_req(lsu_req),
    .lsu_rsp_valid(lsu_rsp_valid), .lsu_rsp(lsu_rsp),
    .fetch_req_valid(fetch_req_valid), .fetch_req_ready(fetch_req_ready),
    .fetch_pc(fetch_pc),
    .fetch_rsp_valid(fetch_rsp_valid), .fetch_instr(fetch_instr)
  );

  always #20 clk = ~clk;

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %0b actual %0b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_load(input string name, input lsu_pkg::lsu_rsp_t expected,
                            input lsu_pkg::lsu_rsp_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %08h actual %08h", name, expected.data, actual.data);
      errors++;
    end
  endtask

  task automatic check_fetch(input string name, input mem_bus_pkg::word32_t expected,
                             input mem_bus_pkg::word32_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  // called on a falling edge, returns on the falling edge that shows the response
  task automatic lsu_access(input lsu_pkg::lsu_req_t req, output lsu_pkg::lsu_rsp_t rsp);
    int n;
    lsu_req       = req;
    lsu_req_valid = 1'b1;
    n = 0;
    while (!lsu_req_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!lsu_req_ready) begin
      $display("timeout: load/store unit never accepted the request at %08h", req.addr);
      timeouts++;
    end
    @(negedge clk);
    lsu_req_valid = 1'b0;
    n = 0;
    while (!lsu_rsp_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!lsu_rsp_valid) begin
      $display("timeout: no load/store response for the access at %08h", req.addr);
      timeouts++;
    end
    rsp = lsu_rsp;
  endtask

  task automatic fetch_access(input mem_bus_pkg::addr_t pc, output mem_bus_pkg::word32_t instr);
    int n;
    fetch_pc        = pc;
    fetch_req_valid = 1'b1;
    n = 0;
    while (!fetch_req_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!fetch_req_ready) begin
      $display("timeout: fetch unit never accepted the pc %08h", pc);
      timeouts++;
    end
    @(negedge clk);
    fetch_req_valid = 1'b0;
    n = 0;
    while (!fetch_rsp_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!fetch_rsp_valid) begin
      $display("timeout: no fetch response for the pc %08h", pc);
      timeouts++;
    end
    instr = fetch_instr;
  endtask

  task automatic run_vector(input int idx);
    logic [31:0]          kind;
    lsu_pkg::lsu_req_t    req;
    lsu_pkg::lsu_rsp_t    exp_rsp;
    lsu_pkg::lsu_rsp_t    got_rsp;
    mem_bus_pkg::word32_t got_instr;
    mem_bus_pkg::addr_t   pc;
    string                name;
    kind            = vec_mem[6*idx];
    req.store       = (kind == KIND_STORE);
    req.addr        = vec_mem[6*idx+1];
    req.size        = lsu_pkg::mem_size_e'(vec_mem[6*idx+2][1:0]);
    req.is_unsigned = vec_mem[6*idx+3][0];
    req.data        = vec_mem[6*idx+4];
    exp_rsp.data    = vec_mem[6*idx+5];
    pc              = {req.addr[31:2], 2'b00};
    name            = $sformatf("vector %0d at %08h", idx, req.addr);
    case (kind)
      KIND_STORE, KIND_LOAD: begin
        lsu_access(req, got_rsp);
        check_load(name, exp_rsp, got_rsp);
      end
      KIND_FETCH: begin
        fetch_access(pc, got_instr);
        check_fetch(name, vec_mem[6*idx+5], got_instr);
      end
      KIND_PAIR: begin
        // both requests go out on the same edge
        fork
          lsu_access(req, got_rsp);
          fetch_access(pc, got_instr);
        join
        check_load({name, " load"}, exp_rsp, got_rsp);
        check_fetch({name, " fetch"}, vec_mem[6*idx+4], got_instr);
      end
      default: begin
        $display("vector %0d has an unknown kind %0d", idx, kind);
        errors++;
      end
    endcase
  endtask

  initial begin
    int idx;
    clk             = 1'b0;
    rst             = 1'b1;
    lsu_req_valid   = 1'b0;
    lsu_req         = '0;
    fetch_req_valid = 1'b0;
    fetch_pc        = '0;
    errors          = 0;
    timeouts        = 0;
    for (int i = 0; i < 6*MAX_VEC; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("bench/mem_subsys_stim.txt", vec_mem);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle outputs right after reset
    repeat (3) begin
      @(negedge clk);
      check_flag("reset lsu_rsp_valid", 1'b0, lsu_rsp_valid);
      check_flag("reset fetch_rsp_valid", 1'b0, fetch_rsp_valid);
      check_flag("reset lsu_req_ready", 1'b1, lsu_req_ready);
      check_flag("reset fetch_req_ready", 1'b1, fetch_req_ready);
    end
    idx = 0;
    while (idx < MAX_VEC && vec_mem[6*idx] != KIND_END) begin
      run_vector(idx);
      idx++;
    end
    if (idx == 0) begin
      $display("no vectors were read from the data file");
      errors++;
    end
    $display("%0d vectors, %0d errors, %0d timeouts", idx, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [1:0]                  in_req_valid,
  output logic [1:0]                  in_req_ready,
  input  mem_bus_pkg::bus_req_t [1:0] in_req,
  output logic [1:0]                  in_rsp_valid,
  input  logic [1:0]                  in_rsp_ready,
  output mem_bus_pkg::bus_rsp_t [1:0] in_rsp,
  output logic                        out_req_valid,
  input  logic                        out_req_ready,
  output mem_bus_pkg::bus_req_t       out_req,
  input  logic                        out_rsp_valid,
  output logic                        out_rsp_ready,
  input  mem_bus_pkg::bus_rsp_t       out_rsp
);

  logic busy;
  logic owner;
  logic last_served;
  logic pick;

  // round robin on a tie, otherwise whoever asks
  always_comb begin
    if (&in_req_valid) begin
      pick = !last_served;
    end else begin
      pick = in_req_valid[1];
    end
  end

  // new requests only while nothing is in flight
  assign out_req_valid = !busy && (|in_req_valid);
  assign out_req       = in_req[pick];

  always_comb begin
    in_req_ready       = '0;
    in_req_ready[pick] = !busy && out_req_ready;
  end

  // response back to the owner
  always_comb begin
    in_rsp_valid        = '0;
    in_rsp_valid[owner] = busy && out_rsp_valid;
  end

  assign out_rsp_ready = busy && in_rsp_ready[owner];
  assign in_rsp        = {out_rsp, out_rsp};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      owner       <= 1'b0;
      last_served <= 1'b1;
    end else if (!busy) begin
      if (out_req_valid && out_req_ready) begin
        busy        <= 1'b1;
        owner       <= pick;
        last_served <= pick;
      end
    end else if (out_rsp_valid && out_rsp_ready) begin
      busy <= 1'b0;
    end
  end

  // memory never answers outside a granted transaction
  assert property (@(posedge clk) disable iff (rst)
    out_rsp_valid |-> busy);

endmodule

/* hw/data_sram.sv */
`timescale 1ns/1ns

module data_sram #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  mem_bus_pkg::bus_req_t req,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output mem_bus_pkg::bus_rsp_t rsp
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);

  mem_bus_pkg::bus_data_t mem [DEPTH_WORDS];
  mem_bus_pkg::bus_data_t rd_q;
  logic                   pending;
  logic [IDX_W-1:0]       idx;

  // doubleword index, low three bits are the byte lane
  assign idx = req.addr[3 +: IDX_W];

  assign req_ready = !pending;
  assign rsp_valid = pending;
  assign rsp.data  = rd_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (req_valid && req_ready) begin
      pending <= 1'b1;
    end else if (pending && rsp_ready) begin
      pending <= 1'b0;
    end
  end

  // read returns the word as it was before this write
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      rd_q <= mem[idx];
      if (req.write) begin
        for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
          if (req.strb[b]) mem[idx][8*b +: 8] <= req.data.bytes[b];
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready |-> (req.addr >> 3) < DEPTH_WORDS);

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  mem_bus_pkg::addr_t    pc,
  output logic                  rsp_valid,
  output mem_bus_pkg::word32_t  instr,
  output logic                  bus_req_valid,
  input  logic                  bus_req_ready,
  output mem_bus_pkg::bus_req_t bus_req,
  input  logic                  bus_rsp_valid,
  output logic                  bus_rsp_ready,
  input  mem_bus_pkg::bus_rsp_t bus_rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RSP
  } state_e;

  state_e               state;
  mem_bus_pkg::addr_t   pc_q;
  mem_bus_pkg::word32_t instr_q;

  assign req_ready     = (state == ST_IDLE);
  assign bus_req_valid = (state == ST_REQ);
  assign bus_rsp_ready = 1'b1;
  assign instr         = instr_q;

  // plain doubleword read
  assign bus_req.addr  = {pc_q[31:3], 3'b000};
  assign bus_req.write = 1'b0;
  assign bus_req.data  = '0;
  assign bus_req.strb  = '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        ST_IDLE: if (req_valid) state <= ST_REQ;
        ST_REQ:  if (bus_req_ready) state <= ST_RSP;
        ST_RSP: begin
          if (bus_rsp_valid) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      pc_q <= pc;
    end
    // pc bit 2 picks the half
    if (bus_rsp_valid && state == ST_RSP) begin
      instr_q <= bus_rsp.data.halves[pc_q[2]];
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready |-> pc[1:0] == 2'b00);

endmodule

/* hw/load_store_unit.sv */
`timescale 1ns/1ns

module load_store_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  lsu_pkg::lsu_req_t     req,
  output logic                  rsp_valid,
  output lsu_pkg::lsu_rsp_t     rsp,
  output logic                  bus_req_valid,
  input  logic                  bus_req_ready,
  output mem_bus_pkg::bus_req_t bus_req,
  input  logic                  bus_rsp_valid,
  output logic                  bus_rsp_ready,
  input  mem_bus_pkg::bus_rsp_t bus_rsp
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ0,
    ST_RSP0,
    ST_REQ1,
    ST_RSP1
  } state_e;

  state_e                 state;
  lsu_pkg::lsu_req_t      req_q;
  mem_bus_pkg::mem_word_u beat0_q;
  mem_bus_pkg::mem_word_u beat1_q;

  logic [2:0]       offset;
  logic [3:0]       size_mask;
  logic [15:0]      line_strb;
  logic [127:0]     line_data;
  logic             crosses;
  logic             second_beat;
  logic             sign_ext;
  logic [15:0][7:0] line_bytes;
  logic [3:0][7:0]  ld_bytes;

  assign offset = req_q.addr[2:0];

  always_comb begin
    case (req_q.size)
      lsu_pkg::size_byte: size_mask = 4'b0001;
      lsu_pkg::size_half: size_mask = 4'b0011;
      default:            size_mask = 4'b1111;
    endcase
  end

  // strobes and data laid out over two doublewords
  // the upper half only matters when the access crosses
  assign line_strb = {12'b0, size_mask} << offset;
  assign line_data = {96'b0, req_q.data} << {offset, 3'b000};
  assign crosses   = |line_strb[15:8];

  assign second_beat = (state == ST_REQ1) || (state == ST_RSP1);

  assign req_ready     = (state == ST_IDLE);
  assign bus_req_valid = (state == ST_REQ0) || (state == ST_REQ1);
  assign bus_rsp_ready = 1'b1;

  always_comb begin
    bus_req.addr  = {req_q.addr[31:3] + 29'(second_beat), 3'b000};
    bus_req.write = req_q.store;
    if (second_beat) begin
      bus_req.data.bytes = line_data[127:64];
      bus_req.strb       = line_strb[15:8];
    end else begin
      bus_req.data.bytes = line_data[63:0];
      bus_req.strb       = line_strb[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state <= ST_REQ0;
          end
        end
        ST_REQ0: begin
          if (bus_req_ready) begin
            state <= ST_RSP0;
          end
        end
        ST_RSP0: begin
          if (bus_rsp_valid) begin
            if (crosses) begin
              state <= ST_REQ1;
            end else begin
              state     <= ST_IDLE;
              rsp_valid <= 1'b1;
            end
          end
        end
        ST_REQ1: begin
          if (bus_req_ready) begin
            state <= ST_RSP1;
          end
        end
        ST_RSP1: begin
          if (bus_rsp_valid) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request and returned doublewords
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    if (bus_rsp_valid && state == ST_RSP0) begin
      beat0_q <= bus_rsp.data;
    end
    if (bus_rsp_valid && state == ST_RSP1) begin
      beat1_q <= bus_rsp.data;
    end
  end

  // second beat bytes sit directly above the first
  assign line_bytes = {beat1_q.bytes, beat0_q.bytes};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      ld_bytes[i] = line_bytes[{1'b0, offset} + 4'(i)];
    end
  end

  assign sign_ext = !req_q.is_unsigned;

  always_comb begin
    rsp.data = '0;
    if (!req_q.store) begin
      case (req_q.size)
        lsu_pkg::size_byte: begin
          rsp.data = {{24{sign_ext && ld_bytes[0][7]}}, ld_bytes[0]};
        end
        lsu_pkg::size_half: begin
          rsp.data = {{16{sign_ext && ld_bytes[1][7]}}, ld_bytes[1], ld_bytes[0]};
        end
        default: rsp.data = ld_bytes;
      endcase
    end
  end

  // waiting request must not change under the arbiter
  assert property (@(posedge clk) disable iff (rst)
    bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req));

  // second beat only when offset plus access size runs past the doubleword
  assert property (@(posedge clk) disable iff (rst)
    bus_req_valid && bus_req_ready && second_beat
    |-> 4'(req_q.addr[2:0]) + (4'd1 << req_q.size) > 4'd8);

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

  // access width of a load or store
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  // request from the core side, 68 bits
  typedef struct packed {
    logic                 store;
    logic                 is_unsigned;
    mem_size_e            size;
    mem_bus_pkg::addr_t   addr;
    mem_bus_pkg::word32_t data;
  } lsu_req_t;

  // load result, zero for a store
  typedef struct packed {
    mem_bus_pkg::word32_t data;
  } lsu_rsp_t;

endpackage

/* hw/mem_bus_pkg.sv */
package mem_bus_pkg;

  // shared bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0] word32_t;
  typedef logic [DATA_W-1:0] bus_data_t;
  typedef logic [STRB_W-1:0] bus_strb_t;

  // one memory doubleword
  // the load/store unit works on bytes, the fetch unit on 32-bit halves
  typedef union packed {
    logic [STRB_W-1:0][7:0] bytes;
    logic [1:0][31:0]       halves;
  } mem_word_u;

  // request channel payload, 105 bits
  typedef struct packed {
    addr_t     addr;
    logic      write;
    mem_word_u data;
    bus_strb_t strb;
  } bus_req_t;

  // response channel payload
  typedef struct packed {
    mem_word_u data;
  } bus_rsp_t;

endpackage

/* hw/mem_subsys.sv */
`timescale 1ns/1ns

module mem_subsys #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lsu_req_valid,
  output logic                 lsu_req_ready,
  input  lsu_pkg::lsu_req_t    lsu_req,
  output logic                 lsu_rsp_valid,
  output lsu_pkg::lsu_rsp_t    lsu_rsp,
  input  logic                 fetch_req_valid,
  output logic                 fetch_req_ready,
  input  mem_bus_pkg::addr_t   fetch_pc,
  output logic                 fetch_rsp_valid,
  output mem_bus_pkg::word32_t fetch_instr
);

  // requester 0 is the load/store unit, 1 the fetch unit
  logic [1:0]                  arb_req_valid;
  logic [1:0]                  arb_req_ready;
  mem_bus_pkg::bus_req_t [1:0] arb_req;
  logic [1:0]                  arb_rsp_valid;
  logic [1:0]                  arb_rsp_ready;
  mem_bus_pkg::bus_rsp_t [1:0] arb_rsp;

  logic                  sram_req_valid;
  logic                  sram_req_ready;
  mem_bus_pkg::bus_req_t sram_req;
  logic                  sram_rsp_valid;
  logic                  sram_rsp_ready;
  mem_bus_pkg::bus_rsp_t sram_rsp;

  load_store_unit lsu_inst (
    .clk(clk), .rst(rst),
    .req_valid(lsu_req_valid), .req_ready(lsu_req_ready), .req(lsu_req),
    .rsp_valid(lsu_rsp_valid), .rsp(lsu_rsp),
    .bus_req_valid(arb_req_valid[0]), .bus_req_ready(arb_req_ready[0]),
    .bus_req(arb_req[0]),
    .bus_rsp_valid(arb_rsp_valid[0]), .bus_rsp_ready(arb_rsp_ready[0]),
    .bus_rsp(arb_rsp[0])
  );

  fetch_unit fetch_inst (
    .clk(clk), .rst(rst),
    .req_valid(fetch_req_valid), .req_ready(fetch_req_ready), .pc(fetch_pc),
    .rsp_valid(fetch_rsp_valid), .instr(fetch_instr),
    .bus_req_valid(arb_req_valid[1]), .bus_req_ready(arb_req_ready[1]),
    .bus_req(arb_req[1]),
    .bus_rsp_valid(arb_rsp_valid[1]), .bus_rsp_ready(arb_rsp_ready[1]),
    .bus_rsp(arb_rsp[1])
  );

  bus_arbiter arb_inst (
    .clk(clk), .rst(rst),
    .in_req_valid(arb_req_valid), .in_req_ready(arb_req_ready), .in_req(arb_req),
    .in_rsp_valid(arb_rsp_valid), .in_rsp_ready(arb_rsp_ready), .in_rsp(arb_rsp),
    .out_req_valid(sram_req_valid), .out_req_ready(sram_req_ready), .out_req(sram_req),
    .out_rsp_valid(sram_rsp_valid), .out_rsp_ready(sram_rsp_ready), .out_rsp(sram_rsp)
  );

  data_sram #(.DEPTH_WORDS(DEPTH_WORDS)) sram_inst (
    .clk(clk), .rst(rst),
    .req_valid(sram_req_valid), .req_ready(sram_req_ready), .req(sram_req),
    .rsp_valid(sram_rsp_valid), .rsp_ready(sram_rsp_ready), .rsp(sram_rsp)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mem_subsys_tb -f all.f -o mem_subsys_sim

status=0
./obj_dir/mem_subsys_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "test failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished cleanly"
